// ==== bench/main_board_properties.sv ====
// Main board bus properties
// Concurrent checks bound to the main board top level: one-hot chip
// selects, no sub grant out of a main-owned RAM, and interrupt release

`default_nettype none

module main_board_properties (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rom_cs,
    input  logic                  vram_cs,
    input  logic                  vctrl_cs,
    input  logic                  pal_cs,
    input  logic                  ram_cs,
    input  main_bus_pkg::owner_t  owner,
    input  logic                  sub_grant,
    input  logic                  lvbl,
    input  logic                  iorq_n,
    input  logic                  int_n
);
    import main_bus_pkg::*;

    int fail_count = 0;

    one_chip_select: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({rom_cs, vram_cs, vctrl_cs, pal_cs, ram_cs})
    ) else begin
        fail_count = fail_count + 1;
        $error("more than one chip select high");
    end

    // A main owner must release to none before the sub side can win
    no_grant_from_main: assert property (
        @(posedge clk) disable iff (rst)
        owner == own_main |=> !$rose(sub_grant)
    ) else begin
        fail_count = fail_count + 1;
        $error("sub grant rose while main CPU owned the RAM");
    end

    // A new vblank edge in the same clock keeps the interrupt pending
    ack_releases_int: assert property (
        @(posedge clk) disable iff (rst)
        !iorq_n && !$fell(lvbl) |=> int_n
    ) else begin
        fail_count = fail_count + 1;
        $error("int_n low after acknowledge");
    end

endmodule

`default_nettype wire

// ==== bench/main_board_tb.sv ====
// Main board testbench
// Acts as the Z80 bus master and the sub CPU, models ROM and video
// read data, and runs a table of accesses against expected values

`default_nettype none

module main_board_tb;
    import main_bus_pkg::*;

    localparam int op_read = 0;
    localparam int op_write = 1;
    localparam int op_sub_wr = 2;
    localparam int op_sub_rd = 3;
    localparam int op_vblank = 4;
    localparam int op_conflict = 5;
    localparam int n_entries = 18;
    localparam int cycle_limit = n_entries * 40;

    logic clk;
    logic rst;
    logic lvbl;
    logic [addr_w-1:0] cpu_addr;
    logic [data_w-1:0] cpu_dout;
    logic mreq_n;
    logic wr_n;
    logic rfsh_n;
    logic iorq_n;
    logic [data_w-1:0] cpu_din;
    logic cpu_wait;
    logic int_n;
    logic vram_cs;
    logic vctrl_cs;
    logic pal_cs;
    logic [data_w-1:0] vram_dout;
    logic [data_w-1:0] pal_dout;
    logic [rom_aw-1:0] rom_addr;
    logic rom_cs;
    logic rom_ok = 1'b0;
    logic [data_w-1:0] rom_data;
    logic snd_rstn;
    logic [ram_aw-1:0] shr_addr;
    logic [data_w-1:0] shr_din;
    logic shr_wr;
    logic shr_cs;
    logic [data_w-1:0] shr_dout;
    logic sub_grant;
    logic [data_w-1:0] st_dout;

    int tb_op [n_entries];
    logic [15:0] tb_addr [n_entries];
    logic [7:0] tb_data [n_entries];
    logic [7:0] tb_exp [n_entries];

    integer seed = 29;
    int cycles = 0;
    int rom_cnt;
    logic [2:0] bank_model;

    main_board DUT (
        .clk(clk), .rst(rst), .lvbl(lvbl),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .mreq_n(mreq_n), .wr_n(wr_n),
        .rfsh_n(rfsh_n), .iorq_n(iorq_n), .cpu_din(cpu_din),
        .cpu_wait(cpu_wait), .int_n(int_n),
        .vram_cs(vram_cs), .vctrl_cs(vctrl_cs), .pal_cs(pal_cs),
        .vram_dout(vram_dout), .pal_dout(pal_dout),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_data(rom_data),
        .snd_rstn(snd_rstn),
        .shr_addr(shr_addr), .shr_din(shr_din), .shr_wr(shr_wr), .shr_cs(shr_cs),
        .shr_dout(shr_dout), .sub_grant(sub_grant), .st_dout(st_dout)
    );

    bind main_board main_board_properties props (
        .clk(clk), .rst(rst), .rom_cs(rom_cs), .vram_cs(vram_cs),
        .vctrl_cs(vctrl_cs), .pal_cs(pal_cs), .ram_cs(ram_cs), .owner(owner),
        .sub_grant(sub_grant), .lvbl(lvbl), .iorq_n(iorq_n), .int_n(int_n)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Device models
    // ROM data is only valid while rom_ok is high
    assign rom_data  = rom_ok ? rom_addr[7:0] ^ 8'ha5 : 8'h00;
    assign vram_dout = cpu_addr[7:0];
    assign pal_dout  = ~cpu_addr[7:0];

    // ROM answers after a random number of cycles
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            rom_ok  <= 1'b0;
            rom_cnt <= 0;
        end else if (!rom_cs) begin
            rom_ok  <= 1'b0;
            rom_cnt <= $random(seed) & 3;
        end else if (rom_cnt == 0) begin
            rom_ok <= 1'b1;
        end else begin
            rom_cnt <= rom_cnt - 1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (DUT.props.fail_count != 0) begin
            $display("error: a bound assertion on the main board failed");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Chip selects of a read from the address map, as {rom, vram, vctrl, pal}
    function automatic logic [3:0] region_selects(input logic [15:0] addr);
        if (addr < 16'hc000)
            return 4'b1000;
        else if (addr < 16'he000)
            return 4'b0100;
        else if (addr >= 16'hf000 && addr < 16'hf500)
            return 4'b0010;
        else if (addr >= 16'hf800 && addr < 16'hfc00)
            return 4'b0001;
        else
            return 4'b0000;
    endfunction

    task automatic set_entry(input int i, input int op, input logic [15:0] addr,
                             input logic [7:0] data, input logic [7:0] exp);
        tb_op[i] = op;
        tb_addr[i] = addr;
        tb_data[i] = data;
        tb_exp[i] = exp;
    endtask

    task automatic load_table();
        set_entry(0,  op_read,     16'h0123, 8'h00, 8'h23 ^ 8'ha5);
        set_entry(1,  op_read,     16'h4567, 8'h00, 8'h67 ^ 8'ha5);
        set_entry(2,  op_read,     16'hc012, 8'h00, 8'h12);
        set_entry(3,  op_read,     16'hf234, 8'h00, 8'h34);
        set_entry(4,  op_read,     16'hf9ab, 8'h00, 8'h54);
        set_entry(5,  op_read,     16'hf7cd, 8'h00, 8'h00);
        set_entry(6,  op_read,     16'hfc00, 8'h00, 8'h00);
        // Bank 5 with the sound CPU running
        set_entry(7,  op_write,    16'hf600, 8'h15, 8'h05);
        set_entry(8,  op_read,     16'h8042, 8'h00, 8'h42 ^ 8'ha5);
        set_entry(9,  op_write,    16'hf603, 8'h03, 8'h13);
        set_entry(10, op_read,     16'hbfff, 8'h00, 8'hff ^ 8'ha5);
        set_entry(11, op_write,    16'he010, 8'h3c, 8'h00);
        set_entry(12, op_sub_rd,   16'h0010, 8'h00, 8'h3c);
        set_entry(13, op_sub_wr,   16'h0123, 8'h9e, 8'h00);
        set_entry(14, op_read,     16'he123, 8'h00, 8'h9e);
        set_entry(15, op_conflict, 16'he010, 8'h00, 8'h3c);
        set_entry(16, op_vblank,   16'h0000, 8'h00, 8'h00);
        set_entry(17, op_read,     16'h0000, 8'h00, 8'ha5);
    endtask

    task automatic start_access(input logic [15:0] addr, input logic [7:0] data,
                                input logic write);
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        wr_n = ~write;
        mreq_n = 1'b0;
        @(posedge clk);
    endtask

    // Hold the bus until wait is low on a rising edge
    task automatic finish_access(output logic [7:0] rd, output logic [16:0] ra,
                                 output logic [3:0] cs);
        do @(negedge clk); while (cpu_wait);
        @(posedge clk);
        @(negedge clk);
        rd = cpu_din;
        ra = rom_addr;
        cs = {rom_cs, vram_cs, vctrl_cs, pal_cs};
        mreq_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic sub_acquire(input logic [15:0] addr);
        @(negedge clk);
        shr_addr = addr[ram_aw-1:0];
        shr_cs = 1'b1;
        do @(negedge clk); while (!sub_grant);
    endtask

    task automatic run_entry(input int i);
        logic [7:0] rd;
        logic [16:0] ra;
        logic [16:0] ra_exp;
        logic [3:0] cs;
        case (tb_op[i])
            op_read: begin
                start_access(tb_addr[i], 8'h00, 1'b0);
                finish_access(rd, ra, cs);
                check("cpu_din", rd, tb_exp[i]);
                check("chip_selects", cs, region_selects(tb_addr[i]));
                if (tb_addr[i] < 16'hc000) begin
                    if (tb_addr[i][15])
                        ra_exp = {bank_model, tb_addr[i][13:0]};
                    else
                        ra_exp = {2'b00, tb_addr[i][14:0]};
                    check("rom_addr", ra, ra_exp);
                end
            end
            op_write: begin
                start_access(tb_addr[i], tb_data[i], 1'b1);
                finish_access(rd, ra, cs);
                if (tb_addr[i][15:8] == 8'hf6) begin
                    bank_model = tb_data[i][2:0];
                    @(negedge clk);
                    check("snd_rstn", snd_rstn, tb_data[i][4]);
                    check("st_dout", st_dout, tb_exp[i]);
                end
            end
            op_sub_wr: begin
                sub_acquire(tb_addr[i]);
                shr_din = tb_data[i];
                shr_wr = 1'b1;
                @(negedge clk);
                shr_wr = 1'b0;
                shr_cs = 1'b0;
            end
            op_sub_rd: begin
                sub_acquire(tb_addr[i]);
                @(negedge clk);
                check("shr_dout", shr_dout, tb_exp[i]);
                shr_cs = 1'b0;
            end
            op_conflict: begin
                sub_acquire(16'h0000);
                start_access(tb_addr[i], 8'h00, 1'b0);
                repeat (3) begin
                    @(negedge clk);
                    check("cpu_wait", cpu_wait, 1'b1);
                end
                shr_cs = 1'b0;
                finish_access(rd, ra, cs);
                check("cpu_din", rd, tb_exp[i]);
            end
            op_vblank: begin
                @(negedge clk);
                lvbl = 1'b0;
                repeat (2) @(negedge clk);
                check("int_n", int_n, 1'b0);
                iorq_n = 1'b0;
                @(negedge clk);
                iorq_n = 1'b1;
                lvbl = 1'b1;
                check("int_n", int_n, 1'b1);
            end
            default: begin
                $display("unknown operation in stimulus table entry %0d", i);
                $display("TESTS FAILED");
                $fatal(1);
            end
        endcase
        @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        lvbl = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        mreq_n = 1'b1;
        wr_n = 1'b1;
        rfsh_n = 1'b1;
        iorq_n = 1'b1;
        shr_addr = '0;
        shr_din = '0;
        shr_wr = 1'b0;
        shr_cs = 1'b0;
        bank_model = 3'd0;
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("chip_selects", {rom_cs, vram_cs, vctrl_cs, pal_cs}, 4'h0);
        check("snd_rstn", snd_rstn, 1'b0);
        check("int_n", int_n, 1'b1);
        check("cpu_wait", cpu_wait, 1'b0);
        check("sub_grant", sub_grant, 1'b0);
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        if (DUT.props.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("error: a bound assertion on the main board failed");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dual_port_ram.sv ====
// Dual-port work RAM
// Two independent synchronous read/write ports over the shared
// work RAM. Read data is registered one clock after the address

`default_nettype none

module dual_port_ram (
    input  logic                              clk,
    // Main CPU side
    input  logic [main_bus_pkg::ram_aw-1:0]   addr0,
    input  logic [main_bus_pkg::data_w-1:0]   data0,
    input  logic                              we0,
    output logic [main_bus_pkg::data_w-1:0]   q0,
    // Sub CPU side
    input  logic [main_bus_pkg::ram_aw-1:0]   addr1,
    input  logic [main_bus_pkg::data_w-1:0]   data1,
    input  logic                              we1,
    output logic [main_bus_pkg::data_w-1:0]   q1
);
    import main_bus_pkg::*;

    logic [data_w-1:0] mem [2**ram_aw];

    // The arbiter never enables both writes at once
    always_ff @(posedge clk) begin
        if (we0) begin
            mem[addr0] <= data0;
        end
        if (we1) begin
            mem[addr1] <= data1;
        end
        // Read before write on either port
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

// ==== verilog/main_board.sv ====
// Main CPU board glue
// Connects the Z80 bus to the address decoder, the shared work RAM
// and its arbiter, and the vertical blank interrupt. Returns read data
// through a registered priority mux and raises wait while the ROM has
// no data or the sub CPU holds the work RAM

`default_nettype none

module main_board (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              lvbl,
    // Z80 bus
    input  logic [main_bus_pkg::addr_w-1:0]   cpu_addr,
    input  logic [main_bus_pkg::data_w-1:0]   cpu_dout,
    input  logic                              mreq_n,
    input  logic                              wr_n,
    input  logic                              rfsh_n,
    input  logic                              iorq_n,
    output logic [main_bus_pkg::data_w-1:0]   cpu_din,
    output logic                              cpu_wait,
    output logic                              int_n,
    // Video
    output logic                              vram_cs,
    output logic                              vctrl_cs,
    output logic                              pal_cs,
    input  logic [main_bus_pkg::data_w-1:0]   vram_dout,
    input  logic [main_bus_pkg::data_w-1:0]   pal_dout,
    // Program ROM
    output logic [main_bus_pkg::rom_aw-1:0]   rom_addr,
    output logic                              rom_cs,
    input  logic                              rom_ok,
    input  logic [main_bus_pkg::data_w-1:0]   rom_data,
    // Sound CPU
    output logic                              snd_rstn,
    // Sub CPU access to the work RAM
    input  logic [main_bus_pkg::ram_aw-1:0]   shr_addr,
    input  logic [main_bus_pkg::data_w-1:0]   shr_din,
    input  logic                              shr_wr,
    input  logic                              shr_cs,
    output logic [main_bus_pkg::data_w-1:0]   shr_dout,
    output logic                              sub_grant,
    // Status
    output logic [main_bus_pkg::data_w-1:0]   st_dout
);
    import main_bus_pkg::*;

    logic              ram_cs;
    logic [bank_w-1:0] bank;
    logic [data_w-1:0] ram_dout;
    logic [data_w-1:0] rd_mux;
    owner_t            owner;
    logic              we_main;
    logic              we_sub;

    main_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .mreq_n   (mreq_n),
        .rfsh_n   (rfsh_n),
        .wr_n     (wr_n),
        .rom_cs   (rom_cs),
        .vram_cs  (vram_cs),
        .vctrl_cs (vctrl_cs),
        .pal_cs   (pal_cs),
        .ram_cs   (ram_cs),
        .rom_addr (rom_addr),
        .bank     (bank),
        .snd_rstn (snd_rstn)
    );

    shared_ram_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .main_req (ram_cs),
        .main_wr  (~wr_n),
        .sub_req  (shr_cs),
        .sub_wr   (shr_wr),
        .owner    (owner),
        .we_main  (we_main),
        .we_sub   (we_sub)
    );

    dual_port_ram u_ram (
        .clk   (clk),
        .addr0 (cpu_addr[ram_aw-1:0]),
        .data0 (cpu_dout),
        .we0   (we_main),
        .q0    (ram_dout),
        .addr1 (shr_addr),
        .data1 (shr_din),
        .we1   (we_sub),
        .q1    (shr_dout)
    );

    // Any IORQ cycle acknowledges the interrupt
    vblank_irq u_irq (
        .clk   (clk),
        .rst   (rst),
        .lvbl  (lvbl),
        .ack   (~iorq_n),
        .int_n (int_n)
    );

    assign sub_grant = owner == own_sub;

    // Stall on a ROM miss or a work RAM held by the sub CPU
    assign cpu_wait = (rom_cs & ~rom_ok) | (ram_cs & owner == own_sub);

    always_comb begin
        if (rom_cs) begin
            rd_mux = rom_data;
        end else if (ram_cs) begin
            rd_mux = ram_dout;
        end else if (vram_cs | vctrl_cs) begin
            rd_mux = vram_dout;
        end else if (pal_cs) begin
            rd_mux = pal_dout;
        end else begin
            rd_mux = '0;
        end
    end

    // Held while stalled so the CPU sees only valid data
    always_ff @(posedge clk) begin
        if (!cpu_wait) begin
            cpu_din <= rd_mux;
        end
    end

    // Sound reset shown active high
    assign st_dout = {{(data_w-bank_w-2){1'b0}}, ~snd_rstn, 1'b0, bank};

endmodule

`default_nettype wire

// ==== verilog/main_bus_pkg.sv ====
// Main CPU bus definitions
// Widths of the Z80 bus, the banked ROM and the shared work RAM,
// plus the owner encoding of the shared RAM arbiter

`default_nettype none

package main_bus_pkg;

    localparam int addr_w      = 16;
    localparam int data_w      = 8;

    // 128 kB of program ROM behind a 3-bit bank
    localparam int rom_aw      = 17;
    localparam int bank_w      = 3;

    // 8 kB work RAM seen by both CPUs
    localparam int ram_aw      = 13;

    // Bank write bit that lets the sound CPU run
    localparam int snd_rst_bit = 4;

    // Current holder of the shared RAM
    typedef enum logic [1:0] {
        own_none,
        own_main,
        own_sub
    } owner_t;

endpackage

`default_nettype wire

// ==== verilog/main_decoder.sv ====
// Main CPU address decoder
// Classifies each memory access into a region and registers one-hot
// chip selects one clock after the address. Also holds the ROM bank
// register, which carries the sound CPU reset, and forms the banked
// ROM address

`default_nettype none

module main_decoder (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [main_bus_pkg::addr_w-1:0]   cpu_addr,
    input  logic [main_bus_pkg::data_w-1:0]   cpu_dout,
    input  logic                              mreq_n,
    input  logic                              rfsh_n,
    input  logic                              wr_n,
    output logic                              rom_cs,
    output logic                              vram_cs,
    output logic                              vctrl_cs,
    output logic                              pal_cs,
    output logic                              ram_cs,
    output logic [main_bus_pkg::rom_aw-1:0]   rom_addr,
    output logic [main_bus_pkg::bank_w-1:0]   bank,
    output logic                              snd_rstn
);
    import main_map_pkg::*;
    import main_bus_pkg::*;

    // Address bits inside one 16 kB ROM page
    localparam int page_w = rom_aw - bank_w;

    region_t region;
    logic    mem_acc;
    logic    bank_cs;

    // Refresh cycles also pull mreq_n low
    assign mem_acc = ~mreq_n & rfsh_n;

    always_comb begin
        region = reg_none;
        if (mem_acc) begin
            if (cpu_addr[15:12] < rom_top_nib) begin
                region = reg_rom;
            end else if (cpu_addr[15:13] == vram_top3) begin
                region = reg_vram;
            end else if (cpu_addr[15:12] == ram_nib) begin
                region = reg_ram;
            end else if (cpu_addr[15:12] == io_nib && cpu_addr[11:8] <= vctrl_hi_max) begin
                region = reg_vctrl;
            end else if (cpu_addr[15:8] == bank_page) begin
                region = reg_bank;
            end else if (cpu_addr[15:12] == io_nib && cpu_addr[11:10] == pal_sel) begin
                region = reg_pal;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            vctrl_cs <= 1'b0;
            pal_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            bank_cs  <= 1'b0;
        end else begin
            rom_cs   <= region == reg_rom;
            vram_cs  <= region == reg_vram;
            vctrl_cs <= region == reg_vctrl;
            pal_cs   <= region == reg_pal;
            ram_cs   <= region == reg_ram;
            // Reads of the bank page fall through to zero
            bank_cs  <= region == reg_bank && !wr_n;
        end
    end

    // Data is still held by the CPU while the strobe is high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= '0;
            snd_rstn <= 1'b0;
        end else if (bank_cs) begin
            bank     <= cpu_dout[bank_w-1:0];
            snd_rstn <= cpu_dout[snd_rst_bit];
        end
    end

    // 0000-7FFF maps to the first two pages, 8000-BFFF to the banked one
    assign rom_addr = {
        cpu_addr[addr_w-1] ? bank : {{(bank_w-1){1'b0}}, cpu_addr[page_w]},
        cpu_addr[page_w-1:0]
    };

endmodule

`default_nettype wire

// ==== verilog/main_map_pkg.sv ====
// Main CPU address map
// Page limits used by the board decoder to split the 64 kB Z80 space
// into ROM, video, work RAM, palette and bank register regions

`default_nettype none

package main_map_pkg;

    // Decoded region of one memory access
    typedef enum logic [2:0] {
        reg_none,
        reg_rom,
        reg_vram,
        reg_ram,
        reg_vctrl,
        reg_pal,
        reg_bank
    } region_t;

    // ROM sits below C000
    localparam logic [3:0] rom_top_nib  = 4'hc;

    // Video RAM at C000-DFFF
    localparam logic [2:0] vram_top3    = 3'b110;

    // Work RAM at E000-EFFF, shared with the sub CPU
    localparam logic [3:0] ram_nib      = 4'he;

    // Top page holding video control, bank register and palette
    localparam logic [3:0] io_nib       = 4'hf;

    // Video control at F000-F4FF
    localparam logic [3:0] vctrl_hi_max = 4'h4;

    // Palette at F800-FBFF, selected by A[11:10]
    localparam logic [1:0] pal_sel      = 2'b10;

    // Bank register page, write only
    localparam logic [7:0] bank_page    = 8'hf6;

endpackage

`default_nettype wire

// ==== verilog/shared_ram_arbiter.sv ====
// Shared work RAM arbiter
// First come, first served ownership of the work RAM between the main
// and the sub CPU. The main CPU wins a tie and an owner keeps the RAM
// until its own request drops. Write enables follow ownership

`default_nettype none

module shared_ram_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  main_req,
    input  logic                  main_wr,
    input  logic                  sub_req,
    input  logic                  sub_wr,
    output main_bus_pkg::owner_t  owner,
    output logic                  we_main,
    output logic                  we_sub
);
    import main_bus_pkg::*;

    owner_t owner_nx;

    always_comb begin
        owner_nx = owner;
        case (owner)
            own_none: begin
                if (main_req) begin
                    owner_nx = own_main;
                end else if (sub_req) begin
                    owner_nx = own_sub;
                end
            end
            own_main: begin
                if (!main_req) begin
                    owner_nx = own_none;
                end
            end
            own_sub: begin
                if (!sub_req) begin
                    owner_nx = own_none;
                end
            end
            default: owner_nx = own_none;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner <= own_none;
        end else begin
            owner <= owner_nx;
        end
    end

    // The main CPU only stalls on a sub-owned RAM, so its write
    // lands on the same edge that registers its grant
    assign we_main = main_wr && owner_nx == own_main;

    // Sub side writes only after seeing sub_grant
    assign we_sub  = sub_wr && sub_req && owner == own_sub;

endmodule

`default_nettype wire

// ==== verilog/vblank_irq.sv ====
// Vertical blank interrupt
// Latches a pending interrupt on the falling edge of lvbl and
// releases it when the CPU acknowledges. A new edge wins over
// an acknowledge in the same clock

`default_nettype none

module vblank_irq (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic ack,
    output logic int_n
);
    logic lvbl_l;
    logic pending;
    logic vb_fall;

    assign vb_fall = lvbl_l & ~lvbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l  <= 1'b0;
            pending <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (vb_fall) begin
                pending <= 1'b1;
            end else if (ack) begin
                pending <= 1'b0;
            end
        end
    end

    assign int_n = ~pending;

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/main_map_pkg.sv
verilog/main_bus_pkg.sv
verilog/main_decoder.sv
verilog/shared_ram_arbiter.sv
verilog/dual_port_ram.sv
verilog/vblank_irq.sv
verilog/main_board.sv
bench/main_board_properties.sv
bench/main_board_tb.sv
